// ==== common/i2c_settings.svh ====
// I2C master settings: clock divider, byte-length width and derived SCL phase points
`ifndef I2C_SETTINGS_SVH
`define I2C_SETTINGS_SVH

// system clocks per SCL period, keep it a multiple of 4
`define I2C_CLK_DIV 16

`define I2C_LEN_WIDTH 4            // width of the byte_len field

// one quarter of the SCL period
`define I2C_QUARTER (`I2C_CLK_DIV / 4)

`endif

// ==== common/i2c_pkg.sv ====
// I2C master package: bus byte, length, bit index and divider types, FSM state enum
`include "i2c_settings.svh"

package i2c_pkg;

    typedef logic [7:0]                byte_t;     // one bus byte
    typedef logic [`I2C_LEN_WIDTH-1:0] len_t;      // data byte count per trigger
    typedef logic [2:0]                bit_idx_t;  // bit position, msb first on the wire
    typedef logic [4:0]                div_cnt_t;  // SCL divider count

    // ============================================================
    // transaction FSM
    // ============================================================
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_START = 3'd1,                           // start or repeated start
        ST_SEND  = 3'd2,
        ST_SACK  = 3'd3,                           // slave acks our byte
        ST_RECV  = 3'd4,
        ST_RACK  = 3'd5,                           // master ack or nack
        ST_STOP  = 3'd6
    } i2c_state_t;

endpackage

// ==== common/i2c_links.sv ====
// I2C master interfaces: scl_phase_if (SCL phase ticks) and seq_bit_if (sequencer to bit engine)
`timescale 1ns/100ps

// one-clock strobes, each once per SCL period
interface scl_phase_if;
    logic cond_tick;                               // 1/4 period, start/stop edges
    logic fall_tick;                               // 1/2 period, SCL falls
    logic data_tick;                               // 3/4 period, data changes
    logic rise_tick;                               // end of period, SCL rises

    modport source (
        output cond_tick, fall_tick, data_tick, rise_tick
    );
    modport sink (
        input  cond_tick, fall_tick, data_tick, rise_tick
    );
endinterface

interface seq_bit_if;
    i2c_pkg::i2c_state_t state;
    i2c_pkg::bit_idx_t   bit_idx;
    i2c_pkg::byte_t      tx_byte;
    logic                active;                   // bus in use, start to stop
    logic                restart_next;             // read address phase done
    logic                more_to_read;             // current read byte is not the last
    logic                data_byte;                // byte counts toward byte_over

    modport source (
        output state, bit_idx, tx_byte, active, restart_next, more_to_read, data_byte
    );
    modport sink (
        input  state, bit_idx, tx_byte, active, restart_next, more_to_read, data_byte
    );
endinterface

// ==== hdl/i2c_trigger_sync.sv ====
// trigger synchronizer: pulse edge detect, held start request, double-registered direction
`timescale 1ns/100ps

module i2c_trigger_sync (
    input  logic clk,
    input  logic rstn,
    input  logic pulse,
    input  logic wr,
    input  logic started,
    output logic start_req,
    output logic wr_sync
);

    logic pulse_1d;
    logic pulse_2d;
    logic pulse_3d;
    logic wr_1d;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            pulse_1d  <= 1'b0;
            pulse_2d  <= 1'b0;
            pulse_3d  <= 1'b0;
            wr_1d     <= 1'b0;
            wr_sync   <= 1'b0;
            start_req <= 1'b0;
        end
        else
        begin
            pulse_1d <= pulse;
            pulse_2d <= pulse_1d;                  // synchronized
            pulse_3d <= pulse_2d;                  // edge reference
            wr_1d    <= wr;
            wr_sync  <= wr_1d;
            if (started)
                start_req <= 1'b0;                 // consumed by the sequencer
            else if (pulse_2d && !pulse_3d)
                start_req <= 1'b1;
        end
    end

    // a new edge while a request is still pending would be lost
    a_edge_not_pending: assert property (@(posedge clk) disable iff (!rstn)
        (pulse_2d && !pulse_3d) |-> !start_req);

endmodule

// ==== hdl/scl_phase_gen.sv ====
// SCL phase generator: free-running divider and the four per-period phase ticks
`timescale 1ns/100ps
`include "i2c_settings.svh"

module scl_phase_gen (
    input  logic               clk,
    input  logic               rstn,
    scl_phase_if.source        phase
);

    i2c_pkg::div_cnt_t div_cnt;

    always_ff @(posedge clk)
    begin
        if (!rstn)
            div_cnt <= '0;
        else if (div_cnt == i2c_pkg::div_cnt_t'(`I2C_CLK_DIV - 1))
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // ============================================================
    // phase decode
    // ============================================================
    assign phase.cond_tick = (div_cnt == i2c_pkg::div_cnt_t'(`I2C_QUARTER - 1));
    assign phase.fall_tick = (div_cnt == i2c_pkg::div_cnt_t'(2 * `I2C_QUARTER - 1));
    assign phase.data_tick = (div_cnt == i2c_pkg::div_cnt_t'(3 * `I2C_QUARTER - 1));
    assign phase.rise_tick = (div_cnt == i2c_pkg::div_cnt_t'(`I2C_CLK_DIV - 1));

endmodule

// ==== i2c_master/i2c_byte_sequencer.sv ====
// byte sequencer: transaction FSM, bit and byte counters, outgoing byte select, busy
`timescale 1ns/100ps
`include "i2c_settings.svh"

module i2c_byte_sequencer (
    input  logic               clk,
    input  logic               rstn,
    input  logic               start_req,
    input  logic               wr_sync,
    input  i2c_pkg::byte_t     device_id,
    input  i2c_pkg::byte_t     reg_addr,
    input  i2c_pkg::byte_t     data_in,
    input  i2c_pkg::len_t      byte_len,
    scl_phase_if.sink          phase,
    output logic               started,
    output logic               busy,
    seq_bit_if.source          seq
);

    i2c_pkg::i2c_state_t       state;
    i2c_pkg::i2c_state_t       state_n;
    i2c_pkg::bit_idx_t         bit_idx;
    i2c_pkg::byte_t            tx_byte;
    logic [`I2C_LEN_WIDTH:0]   byte_cnt;           // id, address and data bytes so far
    logic [`I2C_LEN_WIDTH:0]   byte_max;
    logic                      wr_lat;
    logic                      active;
    logic                      byte_end;
    logic                      stop_done;

    assign started   = start_req && phase.rise_tick && (state == i2c_pkg::ST_IDLE);
    assign byte_end  = ((state == i2c_pkg::ST_SEND) || (state == i2c_pkg::ST_RECV))
                       && phase.data_tick && (bit_idx == 3'd7);
    assign stop_done = (state == i2c_pkg::ST_STOP) && phase.cond_tick;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state    <= i2c_pkg::ST_IDLE;
            bit_idx  <= '0;
            byte_cnt <= '0;
            byte_max <= '0;
            wr_lat   <= 1'b0;
            active   <= 1'b0;
            busy     <= 1'b0;
        end
        else
        begin
            state <= state_n;
            if ((state == i2c_pkg::ST_SEND) || (state == i2c_pkg::ST_RECV))
                bit_idx <= phase.data_tick ? bit_idx + 1'b1 : bit_idx;
            else
                bit_idx <= '0;
            if (started)
            begin
                byte_cnt <= '0;
                wr_lat   <= wr_sync;
                byte_max <= {1'b0, byte_len} + (wr_sync ? 2'd2 : 2'd3);  // + id, addr (+ id)
            end
            else if (byte_end)
                byte_cnt <= byte_cnt + 1'b1;
            active <= started || (active && !stop_done);
            busy   <= start_req || (busy && !stop_done);  // drops one clock after stop edge
        end
    end

    // next byte is picked mid-ack, while SCL is high
    always_ff @(posedge clk)
    begin
        if (started)
            tx_byte <= {device_id[7:1], 1'b0};
        else if ((state == i2c_pkg::ST_SACK) && phase.rise_tick)
        begin
            case (byte_cnt)
                'd1:     tx_byte <= reg_addr;
                'd2:     tx_byte <= wr_lat ? data_in : {device_id[7:1], 1'b1};
                default: tx_byte <= data_in;
            endcase
        end
    end

    // ============================================================
    // FSM, every move on a phase tick
    // ============================================================
    always_comb
    begin
        state_n = state;
        case (state)
            i2c_pkg::ST_IDLE:  if (started) state_n = i2c_pkg::ST_START;
            i2c_pkg::ST_START: if (phase.data_tick) state_n = i2c_pkg::ST_SEND;
            i2c_pkg::ST_SEND:  if (byte_end) state_n = i2c_pkg::ST_SACK;
            i2c_pkg::ST_SACK:
            begin
                if (phase.data_tick)
                begin
                    if (byte_cnt < 'd2)
                        state_n = i2c_pkg::ST_SEND;         // id, then address
                    else if (seq.restart_next)
                        state_n = i2c_pkg::ST_START;        // repeated start
                    else if (!wr_lat)
                        state_n = i2c_pkg::ST_RECV;
                    else if (byte_cnt < byte_max)
                        state_n = i2c_pkg::ST_SEND;
                    else
                        state_n = i2c_pkg::ST_STOP;
                end
            end
            i2c_pkg::ST_RECV:  if (byte_end) state_n = i2c_pkg::ST_RACK;
            i2c_pkg::ST_RACK:
            begin
                if (phase.data_tick)
                    state_n = seq.more_to_read ? i2c_pkg::ST_RECV : i2c_pkg::ST_STOP;
            end
            i2c_pkg::ST_STOP:  if (phase.data_tick) state_n = i2c_pkg::ST_IDLE;
            default:           state_n = i2c_pkg::ST_IDLE;
        endcase
    end

    assign seq.state        = state;
    assign seq.bit_idx      = bit_idx;
    assign seq.tx_byte      = tx_byte;
    assign seq.active       = active;
    assign seq.restart_next = !wr_lat && (byte_cnt == 'd2);
    assign seq.more_to_read = (byte_cnt < byte_max);       // valid in ack after a read byte
    assign seq.data_byte    = (byte_cnt >= (wr_lat ? 'd2 : 'd3));

    a_no_recv_on_write: assert property (@(posedge clk) disable iff (!rstn)
        (state == i2c_pkg::ST_RECV) |-> !wr_lat);

endmodule

// ==== i2c_master/i2c_bit_engine.sv ====
// bit engine: SCL and SDA drive, SDA enable, receive shift register, data_out and byte_over
`timescale 1ns/100ps

module i2c_bit_engine (
    input  logic               clk,
    input  logic               rstn,
    input  logic               sda_in,
    scl_phase_if.sink          phase,
    seq_bit_if.sink            seq,
    output logic               scl,
    output logic               sda_out,
    output logic               sda_out_en,
    output logic               byte_over,
    output i2c_pkg::byte_t     data_out
);

    i2c_pkg::byte_t rx_shift;
    logic           last_sample;                   // eighth bit just taken
    logic           in_recv;

    assign in_recv    = (seq.state == i2c_pkg::ST_RECV);
    assign sda_out_en = !((seq.state == i2c_pkg::ST_SACK) || in_recv);

    // ============================================================
    // SCL and SDA drive
    // ============================================================
    always_ff @(posedge clk)
    begin
        if (!rstn)
            scl <= 1'b1;
        else if (!seq.active)
            scl <= 1'b1;                           // idle bus high
        else if (phase.fall_tick || phase.rise_tick)
            scl <= ~scl;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            sda_out <= 1'b1;
        else
        begin
            case (seq.state)
                i2c_pkg::ST_START:
                begin
                    if (phase.cond_tick)
                        sda_out <= 1'b0;           // start while SCL high
                    else if (phase.data_tick)
                        sda_out <= seq.tx_byte[3'd7 - seq.bit_idx];
                end
                i2c_pkg::ST_SEND: sda_out <= seq.tx_byte[3'd7 - seq.bit_idx];  // msb first
                i2c_pkg::ST_SACK: sda_out <= seq.restart_next && phase.data_tick;
                i2c_pkg::ST_RACK:
                begin
                    if (seq.more_to_read || phase.data_tick)
                        sda_out <= 1'b0;           // ack, or low ahead of stop
                    else
                        sda_out <= 1'b1;           // nack last byte
                end
                i2c_pkg::ST_STOP: if (phase.cond_tick) sda_out <= 1'b1;
                default:          sda_out <= 1'b1;
            endcase
        end
    end

    // ============================================================
    // receive path
    // ============================================================
    always_ff @(posedge clk)
    begin
        if (in_recv && phase.rise_tick)
            rx_shift <= {rx_shift[6:0], sda_in};
        if (last_sample)
            data_out <= rx_shift;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            last_sample <= 1'b0;
            byte_over   <= 1'b0;
        end
        else
        begin
            last_sample <= in_recv && phase.rise_tick && (seq.bit_idx == 3'd7);
            byte_over   <= phase.data_tick && (seq.bit_idx == 3'd7) && seq.data_byte
                           && ((seq.state == i2c_pkg::ST_SEND) || in_recv);
        end
    end

endmodule

// ==== hdl/i2c_master_top.sv ====
// I2C master top level: trigger sync, phase generator, byte sequencer and bit engine
`timescale 1ns/100ps

module i2c_master_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               pulse,
    input  logic               wr,
    input  logic               sda_in,
    input  i2c_pkg::byte_t     device_id,
    input  i2c_pkg::byte_t     reg_addr,
    input  i2c_pkg::byte_t     data_in,
    input  i2c_pkg::len_t      byte_len,
    output logic               busy,
    output logic               byte_over,
    output i2c_pkg::byte_t     data_out,
    output logic               scl,
    output logic               sda_out,
    output logic               sda_out_en
);

    logic start_req;
    logic wr_sync;
    logic started;

    scl_phase_if phase_link ();
    seq_bit_if   seq_link ();

    i2c_trigger_sync i_trigger_sync (
        .clk        (clk),
        .rstn       (rstn),
        .pulse      (pulse),
        .wr         (wr),
        .started    (started),
        .start_req  (start_req),
        .wr_sync    (wr_sync)
    );

    scl_phase_gen i_phase_gen (
        .clk        (clk),
        .rstn       (rstn),
        .phase      (phase_link.source)
    );

    i2c_byte_sequencer i_byte_sequencer (
        .clk        (clk),
        .rstn       (rstn),
        .start_req  (start_req),
        .wr_sync    (wr_sync),
        .device_id  (device_id),
        .reg_addr   (reg_addr),
        .data_in    (data_in),
        .byte_len   (byte_len),
        .phase      (phase_link.sink),
        .started    (started),
        .busy       (busy),
        .seq        (seq_link.source)
    );

    i2c_bit_engine i_bit_engine (
        .clk        (clk),
        .rstn       (rstn),
        .sda_in     (sda_in),
        .phase      (phase_link.sink),
        .seq        (seq_link.sink),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_out_en (sda_out_en),
        .byte_over  (byte_over),
        .data_out   (data_out)
    );

endmodule

// ==== tb/i2c_slave_model.sv ====
// behavioral I2C slave: start and stop detect, bus token log, ack and read data return
`timescale 1ns/100ps

module i2c_slave_model (
    input  logic        scl,
    input  logic        sda,
    input  logic [31:0] read_data,                 // returned first byte in the top bits
    output logic        sda_drive
);

    // log entries are bytes, or markers 100 start, 101 stop, 102 ack, 103 nack
    logic [8:0]     log_mem [0:255];
    int             log_cnt = 0;
    i2c_pkg::byte_t rx_shift;
    i2c_pkg::byte_t tx_shift;
    int             bit_cnt = 0;                   // 0..7 data, 8 ack slot
    int             rd_idx = 0;
    logic           rd_mode = 1'b0;                // slave sends bytes
    logic           rd_next = 1'b0;
    logic           addr_phase = 1'b0;

    initial sda_drive = 1'b1;

    task automatic log_token(input logic [8:0] tok);
        log_mem[log_cnt] = tok;
        log_cnt++;
    endtask

    // ============================================================
    // start and stop, SDA moving while SCL high
    // ============================================================
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            log_token(9'h100);
            bit_cnt    = 0;
            rd_idx     = 0;
            rd_mode    = 1'b0;
            rd_next    = 1'b0;
            addr_phase = 1'b1;                     // device id comes next
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            log_token(9'h101);
            rd_mode   = 1'b0;
            sda_drive = 1'b1;
        end
    end

    // ============================================================
    // bit handling
    // ============================================================
    always @(posedge scl)
    begin
        if (bit_cnt == 8)
        begin
            if (rd_mode)
                log_token(sda ? 9'h103 : 9'h102);  // master ack or nack
            rd_mode = rd_next || (rd_mode && !sda);
            rd_next = 1'b0;
            if (rd_mode)
            begin
                tx_shift = read_data[31 - 8*rd_idx -: 8];
                rd_idx++;
            end
            bit_cnt = 0;
        end
        else
        begin
            if (!rd_mode)
            begin
                rx_shift = {rx_shift[6:0], sda};
                if (bit_cnt == 7)
                begin
                    log_token({1'b0, rx_shift});
                    rd_next    = addr_phase && rx_shift[0];
                    addr_phase = 1'b0;
                end
            end
            bit_cnt++;
        end
    end

    always @(negedge scl)
    begin
        if (rd_mode && (bit_cnt < 8))
            sda_drive = tx_shift[7 - bit_cnt];     // msb first
        else
            sda_drive = !((bit_cnt == 8) && !rd_mode);  // ack every byte we take
    end

endmodule

// ==== tb/tb_i2c_master.sv ====
// testbench for the I2C master: case file stimulus, slave model, compare tasks, watchdog
`timescale 1ns/100ps
`include "i2c_settings.svh"

module tb_i2c_master;

    logic               clk;
    logic               rstn;
    logic               pulse;
    logic               wr;
    i2c_pkg::byte_t     device_id;
    i2c_pkg::byte_t     reg_addr;
    i2c_pkg::byte_t     data_in;
    i2c_pkg::len_t      byte_len;
    logic               busy;
    logic               byte_over;
    i2c_pkg::byte_t     data_out;
    logic               scl;
    logic               sda_out;
    logic               sda_out_en;
    logic               sda_drive;
    logic               sda_line;
    logic [31:0]        slave_data;

    logic               case_wr   [0:15];
    i2c_pkg::byte_t     case_id   [0:15];
    i2c_pkg::byte_t     case_addr [0:15];
    i2c_pkg::len_t      case_len  [0:15];
    logic [31:0]        case_data [0:15];          // byte 0 in the top bits
    int                 n_cases = 0;
    int                 total_bytes = 0;
    int                 fail_cnt = 0;
    int                 log_idx = 0;
    logic               loaded = 1'b0;
    logic [31:0]        rng = 32'h3774;

    assign sda_line = sda_out_en ? sda_out : sda_drive;  // master wins while enabled

    always #5 clk = ~clk;

    i2c_master_top i_i2c_master_top (
        .clk        (clk),
        .rstn       (rstn),
        .pulse      (pulse),
        .wr         (wr),
        .sda_in     (sda_line),
        .device_id  (device_id),
        .reg_addr   (reg_addr),
        .data_in    (data_in),
        .byte_len   (byte_len),
        .busy       (busy),
        .byte_over  (byte_over),
        .data_out   (data_out),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_out_en (sda_out_en)
    );

    i2c_slave_model slave (
        .scl        (scl),
        .sda        (sda_line),
        .read_data  (slave_data),
        .sda_drive  (sda_drive)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic i2c_pkg::byte_t pick_byte(input logic [31:0] v, input int k);
        return v[31 - 8*k -: 8];
    endfunction

    task automatic abort_run(input string why);
        $display("tests failed");
        $fatal(1, "%s", why);
    endtask

    // ============================================================
    // compare tasks
    // ============================================================
    task automatic check_byte(input i2c_pkg::byte_t got, input i2c_pkg::byte_t exp,
                              input string what);
        if (got !== exp)
        begin
            fail_cnt++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run("byte mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            fail_cnt++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run("flag mismatch");
        end
    endtask

    task automatic check_len(input i2c_pkg::len_t got, input i2c_pkg::len_t exp,
                             input string what);
        if (got !== exp)
        begin
            fail_cnt++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run("count mismatch");
        end
    endtask

    task automatic expect_token(input logic marker, input i2c_pkg::byte_t value,
                                input string what);
        logic [8:0] tok;
        check_flag(log_idx < slave.log_cnt, 1'b1, what);  // token must exist
        tok = slave.log_mem[log_idx];
        check_flag(tok[8], marker, what);
        check_byte(tok[7:0], value, what);
        log_idx++;
    endtask

    task automatic load_cases();
        int               fd;
        int               n;
        int               k;
        logic [7:0]       f [0:7];
        logic [8*160-1:0] line_buf;
        fd = $fopen("tb/i2c_cases.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the case file tb/i2c_cases.txt");
            abort_run("missing case file");
        end
        while (!$feof(fd))
        begin
            line_buf = '0;
            if ($fgets(line_buf, fd) != 0)
            begin
                n = $sscanf(line_buf, "%h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n >= 4)                        // comments give no fields
                begin
                    for (k = n; k < 8; k++)
                    begin
                        rng  = next_random(rng);
                        f[k] = rng[7:0];           // padding data
                    end
                    if (f[3] > 8'd4)
                    begin
                        $display("case file holds a byte length above 4");
                        abort_run("bad case file");
                    end
                    case_wr[n_cases]   = f[0][0];
                    case_id[n_cases]   = f[1];
                    case_addr[n_cases] = f[2];
                    case_len[n_cases]  = f[3][3:0];
                    case_data[n_cases] = {f[4], f[5], f[6], f[7]};
                    total_bytes += f[3] + (f[0][0] ? 2 : 3);  // + id, addr (+ id)
                    n_cases++;
                end
            end
        end
        $fclose(fd);
    endtask

    // ============================================================
    // one transaction
    // ============================================================
    task automatic run_case(input int c);
        int k;
        @(posedge clk);
        #1;
        wr         = case_wr[c];
        device_id  = case_id[c];
        reg_addr   = case_addr[c];
        byte_len   = case_len[c];
        data_in    = case_wr[c] ? pick_byte(case_data[c], 0) : 8'h00;
        slave_data = case_data[c];
        check_flag(busy, 1'b0, "busy before trigger");
        log_idx = slave.log_cnt;
        @(posedge clk);
        #1;
        pulse = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        pulse = 1'b0;
        while (!busy)
            @(negedge clk);
        k = 0;
        while (busy)
        begin
            @(negedge clk);
            if (byte_over)
            begin
                if (!case_wr[c])
                    check_byte(data_out, pick_byte(case_data[c], k), "read data_out");
                k++;
                if (case_wr[c] && (k < 4))
                begin
                    @(posedge clk);
                    #1;
                    data_in = pick_byte(case_data[c], k);  // next write byte
                end
            end
        end
        check_len(i2c_pkg::len_t'(k), case_len[c], "byte_over count");
        check_flag(scl, 1'b1, "scl after stop");
        check_flag(sda_out, 1'b1, "sda_out after stop");
        expect_token(1'b1, 8'h00, "start");
        expect_token(1'b0, {case_id[c][7:1], 1'b0}, "device id with write flag");
        expect_token(1'b0, case_addr[c], "register address");
        if (case_wr[c])
        begin
            for (k = 0; k < case_len[c]; k++)
                expect_token(1'b0, pick_byte(case_data[c], k), "write data");
        end
        else
        begin
            expect_token(1'b1, 8'h00, "repeated start");
            expect_token(1'b0, {case_id[c][7:1], 1'b1}, "device id with read flag");
            for (k = 0; k < case_len[c]; k++)
                expect_token(1'b1, (k == case_len[c] - 1) ? 8'h03 : 8'h02, "master ack");
        end
        expect_token(1'b1, 8'h01, "stop");
        check_flag(log_idx == slave.log_cnt, 1'b1, "no extra bus tokens");
    endtask

    initial
    begin
        wait (loaded);
        // about 40 SCL periods per byte, plus reset
        #((total_bytes * 40 * `I2C_CLK_DIV + 100) * 10);
        $display("watchdog expired, the transactions did not finish in time");
        abort_run("watchdog timeout");
    end

    initial
    begin
        int c;
        clk        = 1'b0;
        rstn       = 1'b0;
        pulse      = 1'b0;
        wr         = 1'b0;
        device_id  = 8'h00;
        reg_addr   = 8'h00;
        data_in    = 8'h00;
        byte_len   = '0;
        slave_data = 32'h0;
        load_cases();
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_flag(scl, 1'b1, "scl after reset");
        check_flag(sda_out, 1'b1, "sda_out after reset");
        check_flag(sda_out_en, 1'b1, "sda_out_en after reset");
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(byte_over, 1'b0, "byte_over after reset");
        for (c = 0; c < n_cases; c++)
            run_case(c);
        if (fail_cnt == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
            abort_run("checks failed");
    end

endmodule

// ==== tb/i2c_cases.txt ====
// columns (hex): wr (1 write, 0 read), device_id, reg_addr, byte_len, data0 .. data3
// data is write data, or the bytes the slave returns; missing data bytes are padded
1 a0 10 1 5a
1 a2 3c 4 01 80 ff 7e
0 a0 10 1 c3
0 5e 7f 4 12 34 56 78
1 77 00 3 e1
0 a1 22 2
0 b4 81 3 ff 00 a5
1 3a c8 2 69 96

// ==== src.f ====
+incdir+common
common/i2c_pkg.sv
common/i2c_links.sv
hdl/i2c_trigger_sync.sv
hdl/scl_phase_gen.sv
i2c_master/i2c_byte_sequencer.sv
i2c_master/i2c_bit_engine.sv
hdl/i2c_master_top.sv
tb/i2c_slave_model.sv
tb/tb_i2c_master.sv
